/* ex_settings.svh */
// Execute stage widths

`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Integer register and data word width
`define EX_XLEN 32

// Half word used by the partial product multiplier
`define EX_HALF_W 16

// Register file address width
`define EX_REG_AW 5

////////////////////////////////////////
// Operator field widths
////////////////////////////////////////

// ALU operator field
`define EX_ALU_OP_W 4

// Multiplier operator field
`define EX_MULT_OP_W 2

`endif

/* ex_pkg.sv */
// Execute stage types

`default_nettype none

`include "ex_settings.svh"

package ex_pkg;

  ////////////////////////////////////////
  // Operator and unit encodings
  ////////////////////////////////////////

  // Target unit of one issued instruction
  typedef enum logic [1:0] {
    UNIT_NONE = 2'd0,
    UNIT_ALU  = 2'd1,
    UNIT_MULT = 2'd2,
    UNIT_LOAD = 2'd3
  } ex_unit_e;

  // ALU operators, branch compares at the top
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13
  } alu_op_e;

  // Multiplier operators
  typedef enum logic [`EX_MULT_OP_W-1:0] {
    MULT_MUL    = 2'd0,
    MULT_MULH   = 2'd1,
    MULT_MULHSU = 2'd2,
    MULT_MULHU  = 2'd3
  } mult_op_e;

  ////////////////////////////////////////
  // Port structs
  ////////////////////////////////////////

  // One instruction from the ID side
  typedef struct packed {
    ex_unit_e                unit;
    alu_op_e                 alu_op;
    mult_op_e                mult_op;
    logic [`EX_XLEN-1:0]     operand_a;
    logic [`EX_XLEN-1:0]     operand_b;
    logic [`EX_XLEN-1:0]     operand_c;
    logic [`EX_REG_AW-1:0]   rd;
    logic                    rf_we;
  } ex_issue_t;

  // ALU and multiplier write port
  typedef struct packed {
    logic                    we;
    logic [`EX_REG_AW-1:0]   waddr;
    logic [`EX_XLEN-1:0]     wdata;
  } ex_fwd_t;

  // Load write port
  typedef struct packed {
    logic                    we;
    logic [`EX_REG_AW-1:0]   waddr;
    logic [`EX_XLEN-1:0]     wdata;
  } ex_wb_t;

endpackage

`default_nettype wire

/* ex_alu.sv */
// Integer ALU

`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_alu (
  input  ex_pkg::alu_op_e        alu_op_i,
  input  wire [`EX_XLEN-1:0]     operand_a_i,
  input  wire [`EX_XLEN-1:0]     operand_b_i,
  output logic [`EX_XLEN-1:0]    result_o,
  output logic                   cmp_result_o
);

  // Shift amount from low bits of b
  logic [4:0] shamt;
  // Shared comparison
  logic       cmp_signed;
  logic       is_lt;
  logic       is_eq;

  assign shamt = operand_b_i[4:0];

  ////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////

  // Only sltu compares unsigned
  assign cmp_signed = (alu_op_i != ex_pkg::ALU_SLTU);

  always_comb begin
    if (cmp_signed) begin
      is_lt = ($signed(operand_a_i) < $signed(operand_b_i));
    end else begin
      is_lt = (operand_a_i < operand_b_i);
    end
  end

  assign is_eq = (operand_a_i == operand_b_i);

  // Compare outcome, also the branch decision
  always_comb begin
    unique case (alu_op_i)
      ex_pkg::ALU_EQ:   cmp_result_o = is_eq;
      ex_pkg::ALU_NE:   cmp_result_o = ~is_eq;
      ex_pkg::ALU_LT,
      ex_pkg::ALU_SLT,
      ex_pkg::ALU_SLTU: cmp_result_o = is_lt;
      ex_pkg::ALU_GE:   cmp_result_o = ~is_lt;
      default:          cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////

  always_comb begin
    unique case (alu_op_i)
      ex_pkg::ALU_ADD: result_o = operand_a_i + operand_b_i;
      ex_pkg::ALU_SUB: result_o = operand_a_i - operand_b_i;
      ex_pkg::ALU_AND: result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:  result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ex_pkg::ALU_SLL: result_o = operand_a_i << shamt;
      ex_pkg::ALU_SRL: result_o = operand_a_i >> shamt;
      // Arithmetic shift keeps the sign
      ex_pkg::ALU_SRA: result_o = $unsigned($signed(operand_a_i) >>> shamt);
      // Set-less-than and branch compares return the flag
      default:         result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

`default_nettype wire

/* ex_mult.sv */
// Integer multiplier

`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_mult (
  input  wire                    clk,
  input  wire                    rst_n,
  input  ex_pkg::mult_op_e       mult_op_i,
  input  wire [`EX_XLEN-1:0]     operand_a_i,
  input  wire [`EX_XLEN-1:0]     operand_b_i,
  input  wire                    start_i,
  input  wire                    step_i,
  output logic [`EX_XLEN-1:0]    result_o
);

  // Partial product and accumulator widths
  localparam int PP_W  = 2 * (`EX_HALF_W + 1);
  localparam int ACC_W = 2 * `EX_XLEN + 2;

  // Operand signedness per operator
  logic                        sign_a;
  logic                        sign_b;
  logic [`EX_XLEN:0]           a_ext;
  logic [`EX_XLEN:0]           b_ext;
  // Halves widened to partial product width
  logic signed [PP_W-1:0]      a_lo;
  logic signed [PP_W-1:0]      a_hi;
  logic signed [PP_W-1:0]      b_lo;
  logic signed [PP_W-1:0]      b_hi;
  logic signed [PP_W-1:0]      pp_ll;
  logic signed [PP_W-1:0]      pp_lh;
  logic signed [PP_W-1:0]      pp_hl;
  logic signed [PP_W-1:0]      pp_hh;
  logic signed [ACC_W-1:0]     acc_q;
  logic signed [ACC_W-1:0]     acc_sum;
  logic [`EX_XLEN-1:0]         prod_lo;

  // Sign extend one partial product to accumulator width
  function automatic logic signed [ACC_W-1:0] widen(input logic signed [PP_W-1:0] pp);
    widen = {{(ACC_W-PP_W){pp[PP_W-1]}}, pp};
  endfunction

  assign sign_a = (mult_op_i == ex_pkg::MULT_MULH) | (mult_op_i == ex_pkg::MULT_MULHSU);
  assign sign_b = (mult_op_i == ex_pkg::MULT_MULH);

  // 33 bit operands, sign or zero extended
  assign a_ext = {sign_a & operand_a_i[`EX_XLEN-1], operand_a_i};
  assign b_ext = {sign_b & operand_b_i[`EX_XLEN-1], operand_b_i};

  ////////////////////////////////////////
  // 16 bit partial products
  ////////////////////////////////////////

  // Low halves unsigned, high halves carry the sign
  assign a_lo = {{(PP_W-`EX_HALF_W){1'b0}}, a_ext[`EX_HALF_W-1:0]};
  assign b_lo = {{(PP_W-`EX_HALF_W){1'b0}}, b_ext[`EX_HALF_W-1:0]};
  assign a_hi = {{(PP_W-`EX_HALF_W-1){a_ext[`EX_XLEN]}}, a_ext[`EX_XLEN:`EX_HALF_W]};
  assign b_hi = {{(PP_W-`EX_HALF_W-1){b_ext[`EX_XLEN]}}, b_ext[`EX_XLEN:`EX_HALF_W]};

  assign pp_ll = a_lo * b_lo;
  assign pp_lh = a_lo * b_hi;
  assign pp_hl = a_hi * b_lo;
  assign pp_hh = a_hi * b_hi;

  // Step 1 loads low x low, step 2 adds both cross terms
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (start_i) begin
      acc_q <= widen(pp_ll);
    end else if (step_i) begin
      acc_q <= acc_q + ((widen(pp_lh) + widen(pp_hl)) <<< `EX_HALF_W);
    end
  end

  // Step 3, high x high joins on the way out
  assign acc_sum = acc_q + (widen(pp_hh) <<< `EX_XLEN);

  // MUL needs only the low word, single cycle
  assign prod_lo = operand_a_i * operand_b_i;

  assign result_o = (mult_op_i == ex_pkg::MULT_MUL) ? prod_lo
                                                    : acc_sum[2*`EX_XLEN-1:`EX_XLEN];

endmodule

`default_nettype wire

/* ex_wb_port.sv */
// Forward and writeback ports

`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_wb_port (
  input  wire                    clk,
  input  wire                    rst_n,
  input  ex_pkg::ex_unit_e       unit_i,
  input  wire                    rf_we_i,
  input  wire [`EX_REG_AW-1:0]   rd_i,
  input  wire [`EX_XLEN-1:0]     alu_result_i,
  input  wire [`EX_XLEN-1:0]     mult_result_i,
  input  wire                    ex_valid_i,
  input  wire                    load_capture_i,
  input  wire                    wb_ready_i,
  input  wire [`EX_XLEN-1:0]     lsu_rdata_i,
  output ex_pkg::ex_fwd_t        fwd_o,
  output ex_pkg::ex_wb_t         wb_o
);

  // EX/WB register of the load destination
  logic                    load_we_q;
  logic [`EX_REG_AW-1:0]   load_waddr_q;
  // Unit writes through the forward port
  logic                    fwd_unit;

  ////////////////////////////////////////
  // Forward port, ALU and multiplier
  ////////////////////////////////////////

  assign fwd_unit = (unit_i == ex_pkg::UNIT_ALU) | (unit_i == ex_pkg::UNIT_MULT);

  assign fwd_o.we    = ex_valid_i & fwd_unit & rf_we_i;
  assign fwd_o.waddr = rd_i;
  assign fwd_o.wdata = (unit_i == ex_pkg::UNIT_MULT) ? mult_result_i : alu_result_i;

  ////////////////////////////////////////
  // Load writeback
  ////////////////////////////////////////

  // Write flag set on capture, dropped once WB takes it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_we_q <= 1'b0;
    end else if (load_capture_i) begin
      load_we_q <= rf_we_i;
    end else if (wb_ready_i) begin
      load_we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_capture_i) begin
      load_waddr_q <= rd_i;
    end
  end

  // Data comes straight from the LSU in the following cycle
  assign wb_o.we    = load_we_q;
  assign wb_o.waddr = load_waddr_q;
  assign wb_o.wdata = lsu_rdata_i;

endmodule

`default_nettype wire

/* ex_ctrl.sv */
// Execute stage control

`timescale 1ns/1ps
`default_nettype none

module ex_ctrl (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    issue_valid_i,
  input  ex_pkg::ex_unit_e       unit_i,
  input  ex_pkg::mult_op_e       mult_op_i,
  input  wire                    wb_ready_i,
  output logic                   ex_ready_o,
  output logic                   ex_valid_o,
  output logic                   mult_start_o,
  output logic                   mult_step_o,
  output logic                   load_capture_o
);

  // Multiply sequencer states
  localparam logic [1:0] SEQ_IDLE = 2'd0;
  localparam logic [1:0] SEQ_STEP = 2'd1;
  localparam logic [1:0] SEQ_DONE = 2'd2;

  logic [1:0] seq_q;
  logic [1:0] seq_d;
  logic       is_mulh;
  logic       accept;

  // High product in EX, needs the three cycle sequence
  assign is_mulh = issue_valid_i & (unit_i == ex_pkg::UNIT_MULT)
                   & (mult_op_i != ex_pkg::MULT_MUL);

  // WB back-pressure stalls everything
  assign ex_ready_o = wb_ready_i & (~is_mulh | (seq_q == SEQ_DONE));
  assign accept     = issue_valid_i & ex_ready_o;
  assign ex_valid_o = accept;

  assign mult_start_o   = is_mulh & wb_ready_i & (seq_q == SEQ_IDLE);
  assign mult_step_o    = is_mulh & wb_ready_i & (seq_q == SEQ_STEP);
  assign load_capture_o = accept & (unit_i == ex_pkg::UNIT_LOAD);

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_comb begin
    seq_d = seq_q;
    if (mult_start_o) begin
      seq_d = SEQ_STEP;
    end else if (mult_step_o) begin
      seq_d = SEQ_DONE;
    end else if (accept) begin
      seq_d = SEQ_IDLE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seq_q <= SEQ_IDLE;
    end else begin
      seq_q <= seq_d;
    end
  end

endmodule

`default_nettype wire

/* ex_stage.sv */
// Execute stage top

`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module ex_stage (
  input  wire                    clk,
  input  wire                    rst_n,
  // Issue from ID
  input  ex_pkg::ex_issue_t      issue_i,
  input  wire                    issue_valid_i,
  output logic                   ex_ready_o,
  // Handshake with WB
  output logic                   ex_valid_o,
  input  wire                    wb_ready_i,
  // Load data from the LSU
  input  wire [`EX_XLEN-1:0]     lsu_rdata_i,
  // Register file write ports
  output ex_pkg::ex_fwd_t        fwd_o,
  output ex_pkg::ex_wb_t         wb_o,
  // To IF
  output logic                   branch_decision_o,
  output logic [`EX_XLEN-1:0]    jump_target_o
);

  logic [`EX_XLEN-1:0] alu_result;
  logic [`EX_XLEN-1:0] mult_result;
  logic                mult_start;
  logic                mult_step;
  logic                load_capture;

  // Jump target passes through from operand c
  assign jump_target_o = issue_i.operand_c;

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  ex_ctrl ctrl_i (
    .clk            ( clk                 ),
    .rst_n          ( rst_n               ),
    .issue_valid_i  ( issue_valid_i       ),
    .unit_i         ( issue_i.unit        ),
    .mult_op_i      ( issue_i.mult_op     ),
    .wb_ready_i     ( wb_ready_i          ),
    .ex_ready_o     ( ex_ready_o          ),
    .ex_valid_o     ( ex_valid_o          ),
    .mult_start_o   ( mult_start          ),
    .mult_step_o    ( mult_step           ),
    .load_capture_o ( load_capture        )
  );

  ////////////////////////////////////////
  // Datapaths
  ////////////////////////////////////////

  // Compare result doubles as the branch decision
  ex_alu alu_i (
    .alu_op_i     ( issue_i.alu_op      ),
    .operand_a_i  ( issue_i.operand_a   ),
    .operand_b_i  ( issue_i.operand_b   ),
    .result_o     ( alu_result          ),
    .cmp_result_o ( branch_decision_o   )
  );

  ex_mult mult_i (
    .clk         ( clk                 ),
    .rst_n       ( rst_n               ),
    .mult_op_i   ( issue_i.mult_op     ),
    .operand_a_i ( issue_i.operand_a   ),
    .operand_b_i ( issue_i.operand_b   ),
    .start_i     ( mult_start          ),
    .step_i      ( mult_step           ),
    .result_o    ( mult_result         )
  );

  ex_wb_port wb_port_i (
    .clk            ( clk                 ),
    .rst_n          ( rst_n               ),
    .unit_i         ( issue_i.unit        ),
    .rf_we_i        ( issue_i.rf_we       ),
    .rd_i           ( issue_i.rd          ),
    .alu_result_i   ( alu_result          ),
    .mult_result_i  ( mult_result         ),
    .ex_valid_i     ( ex_valid_o          ),
    .load_capture_i ( load_capture        ),
    .wb_ready_i     ( wb_ready_i          ),
    .lsu_rdata_i    ( lsu_rdata_i         ),
    .fwd_o          ( fwd_o               ),
    .wb_o           ( wb_o                )
  );

endmodule

`default_nettype wire

/* tb_ex_checker.sv */
// Execute stage checker

`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module tb_ex_checker #(
  parameter int NUM_PAT      = 32,
  parameter int SAMPLE_DELAY = 10
) (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    issue_valid_i,
  input  wire                    wb_ready_i,
  input  wire                    ex_ready_i,
  input  wire                    ex_valid_i,
  input  ex_pkg::ex_fwd_t        fwd_i,
  input  ex_pkg::ex_wb_t         wb_i,
  input  wire                    branch_i,
  input  wire [`EX_XLEN-1:0]     jump_target_i,
  output int                     error_count_o,
  output int                     check_count_o,
  output int                     done_count_o
);

  localparam int PAT_W = 188;

  // Same line layout as the pattern file
  typedef struct packed {
    logic [3:0]  unit;
    logic [3:0]  alu_op;
    logic [3:0]  mult_op;
    logic [7:0]  rd;
    logic [3:0]  rf_we;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] ldata;
    logic [31:0] exp;
    logic [3:0]  br;
  } pat_t;

  logic [PAT_W-1:0] pat_mem [0:NUM_PAT-1];
  int               idx       = 0;
  int               ready_cnt = 0;
  int               err_cnt   = 0;
  int               chk_cnt   = 0;
  // Expected EX/WB register, starts in reset state
  logic             exp_wb_we   = 1'b0;
  logic [4:0]       exp_wb_addr = '0;
  logic [31:0]      exp_wb_data = '0;

  assign error_count_o = err_cnt;
  assign check_count_o = chk_cnt;
  assign done_count_o  = idx;

  initial begin
    $readmemh("ex_patterns.hex", pat_mem);
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %s: got %h, expected %h (pattern %0d, %0t)", name, got, exp, idx, $time);
    end
  endtask

  ////////////////////////////////////////
  // Per-cycle comparison
  ////////////////////////////////////////

  task automatic check_cycle();
    pat_t              pat;
    ex_pkg::ex_unit_e  unit;
    logic              accepted;
    logic              is_mulh;
    logic              exp_ready;
    logic              fwd_unit;
    int                need;
    int                cnt;
    accepted = issue_valid_i & ex_ready_i;
    pat      = '0;
    unit     = ex_pkg::UNIT_NONE;

    // Back-pressure blocks every transfer
    if (!wb_ready_i) begin
      check_value("ex_ready_o", 32'(ex_ready_i), 32'h0);
      check_value("ex_valid_o", 32'(ex_valid_i), 32'h0);
    end

    if (issue_valid_i && idx < NUM_PAT) begin
      pat     = pat_mem[idx];
      unit    = ex_pkg::ex_unit_e'(pat.unit[1:0]);
      is_mulh = (unit == ex_pkg::UNIT_MULT)
                && (ex_pkg::mult_op_e'(pat.mult_op[1:0]) != ex_pkg::MULT_MUL);
      // High products need three ready cycles, everything else one
      need      = is_mulh ? 3 : 1;
      cnt       = ready_cnt + (wb_ready_i ? 1 : 0);
      exp_ready = wb_ready_i && (cnt >= need);
      check_value("ex_ready_o", 32'(ex_ready_i), 32'(exp_ready));
      check_value("ex_valid_o", 32'(ex_valid_i), 32'(exp_ready));
      check_value("jump_target_o", jump_target_i, pat.c);
      // Branch compares only
      if (pat.alu_op >= ex_pkg::ALU_EQ) begin
        check_value("branch_decision_o", 32'(branch_i), 32'(pat.br[0]));
      end
      fwd_unit = (unit == ex_pkg::UNIT_ALU) || (unit == ex_pkg::UNIT_MULT);
      if (accepted && fwd_unit) begin
        check_value("fwd_o.we", 32'(fwd_i.we), 32'(pat.rf_we[0]));
        check_value("fwd_o.waddr", 32'(fwd_i.waddr), 32'(pat.rd[4:0]));
        check_value("fwd_o.wdata", fwd_i.wdata, pat.exp);
      end else begin
        check_value("fwd_o.we", 32'(fwd_i.we), 32'h0);
      end
      ready_cnt = accepted ? 0 : cnt;
    end else if (issue_valid_i) begin
      if (accepted) begin
        err_cnt++;
        $display("An instruction was accepted past the end of the pattern file");
      end
    end else begin
      // Idle cycle writes nothing
      check_value("ex_valid_o", 32'(ex_valid_i), 32'h0);
      check_value("fwd_o.we", 32'(fwd_i.we), 32'h0);
    end

    // Load writeback against the expected EX/WB register
    check_value("wb_o.we", 32'(wb_i.we), 32'(exp_wb_we));
    if (exp_wb_we) begin
      check_value("wb_o.waddr", 32'(wb_i.waddr), 32'(exp_wb_addr));
      check_value("wb_o.wdata", wb_i.wdata, exp_wb_data);
    end

    // State after the coming rising edge
    if (accepted && idx < NUM_PAT && unit == ex_pkg::UNIT_LOAD) begin
      exp_wb_we   = pat.rf_we[0];
      exp_wb_addr = pat.rd[4:0];
      exp_wb_data = pat.ldata;
    end else if (wb_ready_i) begin
      exp_wb_we = 1'b0;
    end
    if (accepted && idx < NUM_PAT) begin
      idx++;
    end
  endtask

  // Inputs change on the falling edge, so sample well before the rising one
  always begin
    @(negedge clk);
    #(SAMPLE_DELAY);
    if (rst_n) begin
      check_cycle();
    end
  end

endmodule

`default_nettype wire

/* tb_ex_stage.sv */
// Execute stage testbench

`timescale 1ns/1ps
`default_nettype none

`include "ex_settings.svh"

module tb_ex_stage;

  localparam int CLK_PERIOD     = 40;
  localparam int RESET_CYCLES   = 4;
  localparam int NUM_PAT        = 32;
  localparam int PAT_W          = 188;
  localparam int TIMEOUT_CYCLES = 40;

  // One pattern line, fields padded to whole hex digits
  typedef struct packed {
    logic [3:0]  unit;
    logic [3:0]  alu_op;
    logic [3:0]  mult_op;
    logic [7:0]  rd;
    logic [3:0]  rf_we;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] ldata;
    logic [31:0] exp;
    logic [3:0]  br;
  } pat_t;

  logic                   clk = 1'b0;
  logic                   rst_n;
  ex_pkg::ex_issue_t      issue_i;
  logic                   issue_valid_i;
  logic                   wb_ready_i;
  logic [`EX_XLEN-1:0]    lsu_rdata_i;
  logic                   ex_ready_o;
  logic                   ex_valid_o;
  ex_pkg::ex_fwd_t        fwd_o;
  ex_pkg::ex_wb_t         wb_o;
  logic                   branch_decision_o;
  logic [`EX_XLEN-1:0]    jump_target_o;

  logic [PAT_W-1:0]       pat_mem [0:NUM_PAT-1];
  logic [31:0]            lfsr_state = 32'h562a;
  int                     force_low;
  logic                   timed_out;
  int                     err_cnt;
  int                     chk_cnt;
  int                     done_cnt;

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // DUT and checker
  ////////////////////////////////////////

  ex_stage dut_i (
    .clk               ( clk               ),
    .rst_n             ( rst_n             ),
    .issue_i           ( issue_i           ),
    .issue_valid_i     ( issue_valid_i     ),
    .ex_ready_o        ( ex_ready_o        ),
    .ex_valid_o        ( ex_valid_o        ),
    .wb_ready_i        ( wb_ready_i        ),
    .lsu_rdata_i       ( lsu_rdata_i       ),
    .fwd_o             ( fwd_o             ),
    .wb_o              ( wb_o              ),
    .branch_decision_o ( branch_decision_o ),
    .jump_target_o     ( jump_target_o     )
  );

  // Samples a quarter period after each falling edge
  tb_ex_checker #(
    .NUM_PAT      ( NUM_PAT        ),
    .SAMPLE_DELAY ( CLK_PERIOD / 4 )
  ) check_i (
    .clk           ( clk               ),
    .rst_n         ( rst_n             ),
    .issue_valid_i ( issue_valid_i     ),
    .wb_ready_i    ( wb_ready_i        ),
    .ex_ready_i    ( ex_ready_o        ),
    .ex_valid_i    ( ex_valid_o        ),
    .fwd_i         ( fwd_o             ),
    .wb_i          ( wb_o              ),
    .branch_i      ( branch_decision_o ),
    .jump_target_i ( jump_target_o     ),
    .error_count_o ( err_cnt           ),
    .check_count_o ( chk_cnt           ),
    .done_count_o  ( done_cnt          )
  );

  ////////////////////////////////////////
  // Random back-pressure
  ////////////////////////////////////////

  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      lfsr_next = (state >> 1) ^ 32'h8020_0003;
    end else begin
      lfsr_next = state >> 1;
    end
  endfunction

  // One LFSR step per bit
  task automatic take_bits(input int n, output logic [3:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      bits       = {bits[2:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // WB side is ready three cycles out of four
  task automatic drive_wb_ready();
    logic [3:0] bits;
    if (force_low > 0) begin
      wb_ready_i = 1'b0;
      force_low  = force_low - 1;
    end else begin
      take_bits(2, bits);
      wb_ready_i = (bits[1:0] != 2'b00);
    end
  endtask

  ////////////////////////////////////////
  // Issue side
  ////////////////////////////////////////

  // Sample before the rising edge, return on the next falling edge
  task automatic step_cycle(output logic accepted);
    #(CLK_PERIOD / 4);
    accepted = issue_valid_i & ex_ready_o;
    @(negedge clk);
  endtask

  task automatic present_pattern(input int idx);
    pat_t pat;
    pat = pat_mem[idx];
    issue_i.unit      = ex_pkg::ex_unit_e'(pat.unit[1:0]);
    issue_i.alu_op    = ex_pkg::alu_op_e'(pat.alu_op);
    issue_i.mult_op   = ex_pkg::mult_op_e'(pat.mult_op[1:0]);
    issue_i.operand_a = pat.a;
    issue_i.operand_b = pat.b;
    issue_i.operand_c = pat.c;
    issue_i.rd        = pat.rd[4:0];
    issue_i.rf_we     = pat.rf_we[0];
    issue_valid_i     = 1'b1;
  endtask

  // Holds the instruction until the stage takes it
  task automatic wait_accept(input int idx);
    logic accepted;
    int   cycles;
    accepted = 1'b0;
    cycles   = 0;
    while (!accepted && !timed_out) begin
      drive_wb_ready();
      step_cycle(accepted);
      cycles++;
      if (!accepted && cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: pattern %0d was not accepted within %0d cycles", idx, cycles);
        timed_out = 1'b1;
      end
    end
  endtask

  initial begin
    int         p;
    int         k;
    int         gap;
    int         cycles;
    logic       accepted;
    logic [3:0] bits;
    pat_t       pat;
    rst_n         = 1'b0;
    issue_i       = '0;
    issue_valid_i = 1'b0;
    wb_ready_i    = 1'b0;
    lsu_rdata_i   = '0;
    force_low     = 0;
    timed_out     = 1'b0;
    $readmemh("ex_patterns.hex", pat_mem);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    p = 0;
    while (p < NUM_PAT && !timed_out) begin
      // Idle gap of zero to two cycles
      take_bits(2, bits);
      if (bits[1]) begin
        gap = 0;
      end else begin
        gap = int'(bits[0]) + 1;
      end
      for (k = 0; k < gap; k++) begin
        issue_valid_i = 1'b0;
        drive_wb_ready();
        step_cycle(accepted);
      end
      present_pattern(p);
      wait_accept(p);
      // Load data follows one cycle after acceptance, then WB stalls briefly
      pat = pat_mem[p];
      if (ex_pkg::ex_unit_e'(pat.unit[1:0]) == ex_pkg::UNIT_LOAD) begin
        lsu_rdata_i = pat.ldata;
        force_low   = 2;
      end
      p++;
    end

    // Drain the last load writeback
    issue_valid_i = 1'b0;
    force_low     = 0;
    wb_ready_i    = 1'b1;
    cycles        = 0;
    while (wb_o.we && !timed_out) begin
      step_cycle(accepted);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: the last load writeback never left the WB port");
        timed_out = 1'b1;
      end
    end
    step_cycle(accepted);
    step_cycle(accepted);

    if (!timed_out && done_cnt != NUM_PAT) begin
      $display("Only %0d of %0d patterns reached the checker", done_cnt, NUM_PAT);
    end
    $display("Checks: %0d, errors: %0d, patterns checked: %0d of %0d",
             chk_cnt, err_cnt, done_cnt, NUM_PAT);
    if (err_cnt == 0 && !timed_out && done_cnt == NUM_PAT) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* ex_patterns.hex */
// unit_aluop_multop_rd_we_opa_opb_opc_loaddata_expected_branch
// unit 0 none 1 alu 2 mult 3 load, mult 0 mul 1 mulh 2 mulhsu 3 mulhu
1_0_0_01_1_00000005_00000003_00000000_00000000_00000008_0
1_0_0_02_1_7fffffff_00000001_00000000_00000000_80000000_0
1_1_0_03_1_00000003_00000005_00000000_00000000_fffffffe_0
1_2_0_04_1_f0f0f0f0_0ff00ff0_00000000_00000000_00f000f0_0
1_3_0_05_1_f0f0f0f0_0ff00ff0_00000000_00000000_fff0fff0_0
1_4_0_06_1_f0f0f0f0_0ff00ff0_00000000_00000000_ff00ff00_0
1_5_0_07_1_00000001_0000003f_00000000_00000000_80000000_0
1_6_0_08_1_80000000_00000004_00000000_00000000_08000000_0
1_7_0_09_1_80000000_00000004_00000000_00000000_f8000000_0
1_8_0_0a_1_ffffffff_00000001_00000000_00000000_00000001_0
1_9_0_0b_1_ffffffff_00000001_00000000_00000000_00000000_0
1_0_0_0c_0_00000001_00000002_00000000_00000000_00000003_0
0_a_0_00_0_12345678_12345678_00001000_00000000_00000000_1
0_b_0_00_0_12345678_12345678_00002000_00000000_00000000_0
0_c_0_00_0_80000000_00000001_00003000_00000000_00000000_1
0_d_0_00_0_80000000_00000001_00004000_00000000_00000000_0
0_d_0_00_0_00000005_00000005_00005000_00000000_00000000_1
2_0_0_10_1_00000007_fffffffd_00000000_00000000_ffffffeb_0
2_0_0_11_1_00010001_00010001_00000000_00000000_00020001_0
2_0_1_12_1_80000000_80000000_00000000_00000000_40000000_0
2_0_1_13_1_ffffffff_00000002_00000000_00000000_ffffffff_0
2_0_2_14_1_ffffffff_ffffffff_00000000_00000000_ffffffff_0
2_0_3_15_1_ffffffff_ffffffff_00000000_00000000_fffffffe_0
2_0_3_16_1_80000000_00000002_00000000_00000000_00000001_0
2_0_1_17_1_7fffffff_7fffffff_00000000_00000000_3fffffff_0
2_0_2_18_1_80000000_80000000_00000000_00000000_c0000000_0
3_0_0_1a_1_00000000_00000000_00000000_deadbeef_00000000_0
1_0_0_1b_1_00000010_00000020_00000000_00000000_00000030_0
3_0_0_1c_1_00000000_00000000_00000000_0badf00d_00000000_0
3_0_0_1d_1_00000000_00000000_00000000_13579bdf_00000000_0
3_0_0_1e_0_00000000_00000000_00000000_11111111_00000000_0
1_1_0_1f_1_00000000_00000001_00000000_00000000_ffffffff_0

/* tb.f */
+incdir+.
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_wb_port.sv
ex_ctrl.sv
ex_stage.sv
tb_ex_checker.sv
tb_ex_stage.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f tb.f --top-module tb_ex_stage; then
  echo "Verilator build failed"
  exit 1
fi

if ! sim_out=$(./obj_dir/Vtb_ex_stage); then
  echo "$sim_out"
  echo "Simulation exited with an error status"
  exit 1
fi

echo "$sim_out"

if grep -q "TESTBENCH PASSED" <<< "$sim_out"; then
  exit 0
fi
exit 1
